// ==== logic/ed_decode_pkg.sv ====
// ##############################
// ED opcode decode types
// ##############################

package ed_decode_pkg;

    // second opcode byte after the ED prefix.
    typedef logic [7:0] opcode_t;

    // one-hot execution phase, bit 0 is the decode phase.
    typedef logic [4:0] xpt_t;

    // ##############################
    // register pair, opcode bits 5:4
    // ##############################

    typedef enum logic [1:0] {
        pair_bc = 2'b00,
        pair_de = 2'b01,
        pair_hl = 2'b10,
        pair_sp = 2'b11
    } reg_pair_t;

    // ##############################
    // command kinds
    // ##############################

    typedef enum logic [2:0] {
        kind_none    = 3'd0, // no decoded group.
        kind_st_pair = 3'd1, // LD (nn),dd, bit 3 clear.
        kind_ld_pair = 3'd2, // LD dd,(nn), bit 3 set.
        kind_adc_hl  = 3'd3, // ADC HL,dd, bit 3 set.
        kind_sbc_hl  = 3'd4  // SBC HL,dd, bit 3 clear.
    } cmd_kind_t;

    // one command per accepted opcode, 6 bits.
    typedef struct packed {
        cmd_kind_t kind;
        reg_pair_t pair;
        logic      fetch_nn; // operand address follows.
    } ed_cmd_t;

endpackage

// ==== logic/bit_decoder.sv ====
// ##############################
// one-hot bit decoder
// ##############################

`timescale 1ns/10ps

module bit_decoder #(
    parameter int WIDTH = 1
) (
    input  logic                  enable,
    input  logic [WIDTH-1:0]      sel,
    output logic [(1<<WIDTH)-1:0] out
);

    // exactly one output high under enable, none otherwise.
    always_comb begin
        out = '0;
        if (enable) begin
            out[sel] = 1'b1;
        end
    end

endmodule

// ==== logic/ld_nn_dd_decoder.sv ====
// ##############################
// LD (nn),dd / LD dd,(nn) decode
// ##############################

`timescale 1ns/10ps

module ld_nn_dd_decoder
    import ed_decode_pkg::*;
(
    input  logic       enable,
    input  xpt_t       xpt,
    input  opcode_t    source,
    output logic       phase_reset,
    output logic       fetch_nn,
    output logic       group_done,
    output logic [3:0] st_pair,
    output logic [3:0] ld_pair
);

    logic       decoded;
    logic [1:0] dir;

    // ##############################
    // phase 0 group match
    // ##############################

    // pattern 01xxx011 in the decode phase.
    assign decoded = enable && xpt[0]
                  && (source[7:6] == 2'b01)
                  && (source[2:0] == 3'b011);

    assign phase_reset = decoded; // nothing left to do in later phases.
    assign fetch_nn    = decoded;
    assign group_done  = decoded;

    // ##############################
    // direction and pair split
    // ##############################

    bit_decoder #(.WIDTH(1)) u_dir (
        .enable (decoded),
        .sel    (source[3:3]),
        .out    (dir)
    );

    // bit 3 clear, store pair to memory.
    bit_decoder #(.WIDTH(2)) u_st_pair (
        .enable (dir[0]),
        .sel    (source[5:4]),
        .out    (st_pair)
    );

    // bit 3 set, load pair from memory.
    bit_decoder #(.WIDTH(2)) u_ld_pair (
        .enable (dir[1]),
        .sel    (source[5:4]),
        .out    (ld_pair)
    );

endmodule

// ==== logic/adc_sbc_decoder.sv ====
// ##############################
// ADC/SBC HL,dd decode
// ##############################

`timescale 1ns/10ps

module adc_sbc_decoder
    import ed_decode_pkg::*;
(
    input  logic       enable,
    input  xpt_t       xpt,
    input  opcode_t    source,
    output logic [3:0] adc_hl,
    output logic [3:0] sbc_hl
);

    logic       decoded;
    logic [1:0] op;

    // pattern 01xxx010 in the decode phase.
    assign decoded = enable && xpt[0]
                  && (source[7:6] == 2'b01)
                  && (source[2:0] == 3'b010);

    bit_decoder #(.WIDTH(1)) u_op (
        .enable (decoded),
        .sel    (source[3:3]),
        .out    (op)
    );

    // bit 3 clear, subtract with carry.
    bit_decoder #(.WIDTH(2)) u_sbc_pair (
        .enable (op[0]),
        .sel    (source[5:4]),
        .out    (sbc_hl)
    );

    // bit 3 set, add with carry.
    bit_decoder #(.WIDTH(2)) u_adc_pair (
        .enable (op[1]),
        .sel    (source[5:4]),
        .out    (adc_hl)
    );

endmodule

// ==== logic/xpt_sequencer.sv ====
// ##############################
// handshake and phase sequencer
// ##############################

`timescale 1ns/10ps

module xpt_sequencer
    import ed_decode_pkg::*;
#(
    parameter int XPT_STEPS = 5
) (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    req,
    input  opcode_t source_in,
    input  logic    phase_reset,
    output logic    ack,
    output opcode_t source,
    output xpt_t    xpt,
    output logic    enable
);

    typedef enum logic [1:0] {
        seq_idle,     // waiting for req.
        seq_run,      // phases stepping.
        seq_wait_low  // phases done, waiting for req low.
    } seq_state_t;

    seq_state_t state;
    logic       accept;
    logic       last_step;

    // a new req only counts when idle with ack already low.
    assign accept    = (state == seq_idle) && req && !ack;
    assign last_step = xpt[XPT_STEPS-1];
    assign enable    = (state == seq_run);

    // ##############################
    // handshake state and phases
    // ##############################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= seq_idle;
            ack   <= 1'b0;
            xpt   <= '0;
        end else begin
            case (state)
                seq_idle: begin
                    if (accept) begin
                        state <= seq_run;
                        ack   <= 1'b1;
                        xpt   <= xpt_t'(1); // decode phase next cycle.
                    end
                end
                seq_run: begin
                    if (phase_reset || last_step) begin
                        state <= seq_wait_low;
                        xpt   <= '0;
                    end else begin
                        xpt <= xpt << 1;
                    end
                end
                seq_wait_low: begin
                    if (!req) begin
                        state <= seq_idle;
                        ack   <= 1'b0; // closes the four-phase cycle.
                    end
                end
                default: begin
                    state <= seq_idle;
                    ack   <= 1'b0;
                    xpt   <= '0;
                end
            endcase
        end
    end

    // ##############################
    // opcode latch
    // ##############################

    always_ff @(posedge clk) begin
        if (accept) begin
            source <= source_in; // held for all phases.
        end
    end

endmodule

// ==== logic/ed_decode_top.sv ====
// ##############################
// ED group decode top
// ##############################

`timescale 1ns/10ps

module ed_decode_top
    import ed_decode_pkg::*;
#(
    parameter int XPT_STEPS = 5
) (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    req,
    input  opcode_t source,
    output logic    ack,
    output ed_cmd_t cmd,
    output logic    cmd_valid
);

    opcode_t    op_latched;
    xpt_t       xpt;
    logic       enable;
    logic       phase_reset;
    logic       fetch_nn;
    logic       group_done;
    logic [3:0] st_pair;
    logic [3:0] ld_pair;
    logic [3:0] adc_hl;
    logic [3:0] sbc_hl;

    xpt_sequencer #(.XPT_STEPS(XPT_STEPS)) u_sequencer (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .source_in   (source),
        .phase_reset (phase_reset),
        .ack         (ack),
        .source      (op_latched),
        .xpt         (xpt),
        .enable      (enable)
    );

    ld_nn_dd_decoder u_ld_nn_dd (
        .enable      (enable),
        .xpt         (xpt),
        .source      (op_latched),
        .phase_reset (phase_reset),
        .fetch_nn    (fetch_nn),
        .group_done  (group_done),
        .st_pair     (st_pair),
        .ld_pair     (ld_pair)
    );

    adc_sbc_decoder u_adc_sbc (
        .enable (enable),
        .xpt    (xpt),
        .source (op_latched),
        .adc_hl (adc_hl),
        .sbc_hl (sbc_hl)
    );

    // ##############################
    // pulse gathering
    // ##############################

    // OR of all one-hot pair pulses, at most one bit high.
    logic [3:0] pair_oh;
    assign pair_oh = st_pair | ld_pair | adc_hl | sbc_hl;

    always_comb begin
        cmd          = '0;
        cmd.pair     = reg_pair_t'({pair_oh[3] | pair_oh[2], pair_oh[3] | pair_oh[1]});
        cmd.fetch_nn = fetch_nn;
        if (group_done) begin
            cmd.kind = (|ld_pair) ? kind_ld_pair : kind_st_pair;
        end else if (|adc_hl) begin
            cmd.kind = kind_adc_hl;
        end else if (|sbc_hl) begin
            cmd.kind = kind_sbc_hl;
        end
    end

    assign cmd_valid = xpt[0]; // one cycle per accepted opcode.

endmodule

// ==== testbench/tb_clock_gen.sv ====
// ##############################
// testbench clock and reset
// ##############################

`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1; // released away from the active edge.
    end

endmodule

// ==== testbench/ed_decode_assertions.sv ====
// ##############################
// handshake assertions
// ##############################

`timescale 1ns/10ps

module ed_decode_assertions (
    input logic clk,
    input logic arst_n,
    input logic req,
    input logic ack,
    input logic cmd_valid
);

    int failures = 0; // read back by the testbench.

    ack_needs_req: assert property (
        @(posedge clk) disable iff (!arst_n)
        $rose(ack) |-> $past(req)
    ) else begin
        failures++;
        $error("ack rose without a req on the previous clock");
    end

    ack_falls_after_req: assert property (
        @(posedge clk) disable iff (!arst_n)
        $fell(ack) |-> !$past(req)
    ) else begin
        failures++;
        $error("ack fell while req was still high");
    end

    // the command pulse is single cycle and sits inside ack.
    single_cmd_pulse: assert property (
        @(posedge clk) disable iff (!arst_n)
        cmd_valid |=> !cmd_valid
    ) else begin
        failures++;
        $error("cmd_valid lasted more than one cycle");
    end

    cmd_inside_ack: assert property (
        @(posedge clk) disable iff (!arst_n)
        cmd_valid |-> ack
    ) else begin
        failures++;
        $error("cmd_valid high while ack low");
    end

endmodule

// ==== testbench/ed_decode_tb.sv ====
// ##############################
// ED decode testbench
// ##############################

`timescale 1ns/10ps

module ed_decode_tb
    import ed_decode_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int XPT_STEPS    = 5;
    localparam int NUM_VECTORS  = 22;
    localparam int NUM_RANDOM   = 32;
    localparam int HOLD_CYCLES  = 10;
    localparam int CYCLE_LIMIT  = (NUM_VECTORS + NUM_RANDOM + 2) * 12 + RESET_CYCLES;
    localparam logic [31:0] SEED = 32'd30955;

    typedef struct packed {
        opcode_t   op;
        cmd_kind_t kind;
        reg_pair_t pair;
        logic      fetch_nn;
    } vector_t;

    logic        clk;
    logic        arst_n;
    logic        req;
    opcode_t     source;
    logic        ack;
    ed_cmd_t     cmd;
    logic        cmd_valid;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    logic [31:0] rng_state;

    // ##############################
    // stimulus table
    // ##############################

    vector_t table_q [NUM_VECTORS] = '{
        '{8'h43, kind_st_pair, pair_bc, 1'b1},
        '{8'h4B, kind_ld_pair, pair_bc, 1'b1},
        '{8'h53, kind_st_pair, pair_de, 1'b1},
        '{8'h5B, kind_ld_pair, pair_de, 1'b1},
        '{8'h63, kind_st_pair, pair_hl, 1'b1},
        '{8'h6B, kind_ld_pair, pair_hl, 1'b1},
        '{8'h73, kind_st_pair, pair_sp, 1'b1},
        '{8'h7B, kind_ld_pair, pair_sp, 1'b1},
        '{8'h42, kind_sbc_hl,  pair_bc, 1'b0},
        '{8'h4A, kind_adc_hl,  pair_bc, 1'b0},
        '{8'h52, kind_sbc_hl,  pair_de, 1'b0},
        '{8'h5A, kind_adc_hl,  pair_de, 1'b0},
        '{8'h62, kind_sbc_hl,  pair_hl, 1'b0},
        '{8'h6A, kind_adc_hl,  pair_hl, 1'b0},
        '{8'h72, kind_sbc_hl,  pair_sp, 1'b0},
        '{8'h7A, kind_adc_hl,  pair_sp, 1'b0},
        '{8'h40, kind_none,    pair_bc, 1'b0}, // outside both groups.
        '{8'h78, kind_none,    pair_bc, 1'b0},
        '{8'h83, kind_none,    pair_bc, 1'b0},
        '{8'hBB, kind_none,    pair_bc, 1'b0},
        '{8'hC3, kind_none,    pair_bc, 1'b0},
        '{8'h4F, kind_none,    pair_bc, 1'b0}
    };

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    ed_decode_top #(.XPT_STEPS(XPT_STEPS)) u_ed_decode_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .source    (source),
        .ack       (ack),
        .cmd       (cmd),
        .cmd_valid (cmd_valid)
    );

    bind ed_decode_top ed_decode_assertions u_assertions (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .ack       (ack),
        .cmd_valid (cmd_valid)
    );

    // ##############################
    // helpers
    // ##############################

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected command from the opcode bit rules.
    function automatic ed_cmd_t reference_cmd(input opcode_t op);
        ed_cmd_t c;
        c = '0;
        if (op[7:6] == 2'b01 && op[2:0] == 3'b011) begin
            c.kind     = op[3] ? kind_ld_pair : kind_st_pair;
            c.pair     = reg_pair_t'(op[5:4]);
            c.fetch_nn = 1'b1;
        end else if (op[7:6] == 2'b01 && op[2:0] == 3'b010) begin
            c.kind = op[3] ? kind_adc_hl : kind_sbc_hl;
            c.pair = reg_pair_t'(op[5:4]);
        end
        return c;
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [7:0] expected, input logic [7:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error %s %s: expected %h actual %h", name, what, expected, actual);
        end
    endtask

    task automatic check_idle(input string name);
        check_value(name, "ack", 8'd0, 8'(ack));
        check_value(name, "cmd_valid", 8'd0, 8'(cmd_valid));
        check_value(name, "cmd", 8'd0, 8'(cmd));
    endtask

    // one full four-phase handshake from falling edge to falling edge.
    task automatic apply_opcode(input string name, input opcode_t op, input ed_cmd_t exp);
        source = op;
        req    = 1'b1;
        @(negedge clk);
        check_value(name, "ack", 8'd1, 8'(ack));
        check_value(name, "cmd_valid", 8'd1, 8'(cmd_valid));
        check_value(name, "cmd", 8'(exp), 8'(cmd));
        req = 1'b0;
        while (ack !== 1'b0) begin
            @(negedge clk);
        end
    endtask

    task automatic held_req_check(input opcode_t op);
        int pulses;
        pulses = 0;
        source = op;
        req    = 1'b1;
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            if (cmd_valid === 1'b1) begin
                pulses++;
            end
        end
        check_value("held req", "cmd_valid pulses", 8'd1, 8'(pulses));
        check_value("held req", "ack", 8'd1, 8'(ack));
        req = 1'b0;
        @(negedge clk); // ack drops on the first clock with req low.
        check_idle("held req release");
    endtask

    // ##############################
    // main sequence
    // ##############################

    initial begin
        ed_cmd_t exp;
        req    = 1'b0;
        source = '0;
        wait (arst_n === 1'b1);
        @(negedge clk);
        check_idle("after reset");
        for (int i = 0; i < NUM_VECTORS; i++) begin
            exp.kind     = table_q[i].kind;
            exp.pair     = table_q[i].pair;
            exp.fetch_nn = table_q[i].fetch_nn;
            apply_opcode($sformatf("opcode %h", table_q[i].op), table_q[i].op, exp);
        end
        rng_state = SEED;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rng_state = xorshift32(rng_state);
            apply_opcode($sformatf("random %0d opcode %h", i, rng_state[7:0]),
                         rng_state[7:0], reference_cmd(rng_state[7:0]));
        end
        held_req_check(8'h5B);
        error_count += u_ed_decode_top.u_assertions.failures;
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the handshake never completed", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

endmodule

// ==== project.f ====
logic/ed_decode_pkg.sv
logic/bit_decoder.sv
logic/ld_nn_dd_decoder.sv
logic/adc_sbc_decoder.sv
logic/xpt_sequencer.sv
logic/ed_decode_top.sv
testbench/tb_clock_gen.sv
testbench/ed_decode_assertions.sv
testbench/ed_decode_tb.sv

// ==== Makefile ====
TOP := ed_decode_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir

# pass or fail comes from the pass line in the simulation output.
run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir
